// ==== logic/branchPkg.sv ====
/*
  Branch issue path shared definitions
  Datapath widths, station size and the branch condition encoding
*/
`default_nettype none

package branchPkg;

  // ============================================================
  // Widths and sizes
  // ============================================================
  localparam int XLEN       = 32;
  localparam int ROB_BITS   = 3;
  localparam int RS_ENTRIES = 2;

  // ============================================================
  // Branch kinds
  // ============================================================
  // JAL and JALR are unconditional, the rest compare src1 with src2
  typedef enum logic [2:0] {
    BR_EQ   = 3'd0,
    BR_NE   = 3'd1,
    BR_LT   = 3'd2,
    BR_GE   = 3'd3,
    BR_LTU  = 3'd4,
    BR_GEU  = 3'd5,
    BR_JAL  = 3'd6,
    BR_JALR = 3'd7
  } brCond_t;

endpackage

`default_nettype wire

// ==== logic/branchRsEntry.sv ====
/*
  Branch reservation station entry
  Holds one branch, wakes its operands from the result bus, requests select
*/
`timescale 1ns/1ns
`default_nettype none

module branchRsEntry (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush,
  input  logic                          write,
  input  branchPkg::brCond_t            cond,
  input  logic [branchPkg::ROB_BITS-1:0] rob,
  input  logic [branchPkg::ROB_BITS-1:0] tag1,
  input  logic [branchPkg::ROB_BITS-1:0] tag2,
  input  logic [branchPkg::XLEN-1:0]     seqPc,
  input  logic [branchPkg::XLEN-1:0]     predPc,
  input  logic [branchPkg::XLEN-1:0]     target,
  input  logic [branchPkg::XLEN-1:0]     value1,
  input  logic [branchPkg::XLEN-1:0]     value2,
  input  logic                          ready1,
  input  logic                          ready2,
  input  logic                          cdbValid,
  input  logic [branchPkg::ROB_BITS-1:0] cdbRob,
  input  logic [branchPkg::XLEN-1:0]     cdbValue,
  input  logic                          releaseReq,
  output logic                          busy,
  output logic                          selectReq,
  output branchPkg::brCond_t            entryCond,
  output logic [branchPkg::ROB_BITS-1:0] entryRob,
  output logic [branchPkg::XLEN-1:0]     entrySrc1,
  output logic [branchPkg::XLEN-1:0]     entrySrc2,
  output logic [branchPkg::XLEN-1:0]     entrySeqPc,
  output logic [branchPkg::XLEN-1:0]     entryPredPc,
  output logic [branchPkg::XLEN-1:0]     entryTarget
);
  import branchPkg::*;

  logic                src1Ready;
  logic                src2Ready;
  logic [ROB_BITS-1:0] tag1Q;
  logic [ROB_BITS-1:0] tag2Q;
  logic                hit1New;
  logic                hit2New;
  logic                hit1;
  logic                hit2;

  // Bypass for a broadcast landing in the dispatch cycle
  assign hit1New = cdbValid && (cdbRob == tag1);
  assign hit2New = cdbValid && (cdbRob == tag2);

  // Wakeup of operands already held
  assign hit1 = busy && !src1Ready && cdbValid && (cdbRob == tag1Q);
  assign hit2 = busy && !src2Ready && cdbValid && (cdbRob == tag2Q);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      busy      <= 1'b0;
      src1Ready <= 1'b0;
      src2Ready <= 1'b0;
    end else if (write) begin
      busy      <= 1'b1;
      src1Ready <= ready1 || hit1New;
      src2Ready <= ready2 || hit2New;
    end else begin
      if (releaseReq) busy <= 1'b0;
      if (hit1) src1Ready <= 1'b1;
      if (hit2) src2Ready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      entryCond   <= cond;
      entryRob    <= rob;
      entrySeqPc  <= seqPc;
      entryPredPc <= predPc;
      entryTarget <= target;
      tag1Q       <= tag1;
      tag2Q       <= tag2;
      entrySrc1   <= ready1 ? value1 : cdbValue;
      entrySrc2   <= ready2 ? value2 : cdbValue;
    end else begin
      if (hit1) entrySrc1 <= cdbValue;
      if (hit2) entrySrc2 <= cdbValue;
    end
  end

  assign selectReq = busy && src1Ready && src2Ready;

  // Allocation in the select logic must only target a free entry
  assert property (@(posedge clk) disable iff (reset) write |-> !busy)
    else $error("write into a busy station entry");

endmodule

`default_nettype wire

// ==== logic/branchSelect.sv ====
/*
  Branch station control
  Allocates free entries, tracks age and grants the oldest ready entry
*/
`timescale 1ns/1ns
`default_nettype none

module branchSelect (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            flush,
  input  logic                            dispatchValid,
  input  logic                            execute,
  input  logic [branchPkg::RS_ENTRIES-1:0] busy,
  input  logic [branchPkg::RS_ENTRIES-1:0] selectReq,
  output logic [branchPkg::RS_ENTRIES-1:0] writeSel,
  output logic [branchPkg::RS_ENTRIES-1:0] grant,
  output logic [branchPkg::RS_ENTRIES-1:0] releaseReq,
  output logic                            issueGo,
  output logic                            full
);
  import branchPkg::*;

  logic olderIdx;
  logic allocDone;

  // Lowest free entry takes the dispatch
  always_comb begin
    writeSel  = '0;
    allocDone = 1'b0;
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (dispatchValid && !busy[i] && !allocDone) begin
        writeSel[i] = 1'b1;
        allocDone   = 1'b1;
      end
    end
  end

  // Age bit, points at the entry written first
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      olderIdx <= 1'b0;
    end else if (writeSel[0]) begin
      olderIdx <= (busy[1] && !releaseReq[1]) ? 1'b1 : 1'b0;
    end else if (writeSel[1]) begin
      olderIdx <= (busy[0] && !releaseReq[0]) ? 1'b0 : 1'b1;
    end
  end

  // oldest requester wins
  always_comb begin
    grant = '0;
    if (selectReq[olderIdx]) grant[olderIdx] = 1'b1;
    else if (selectReq[~olderIdx]) grant[~olderIdx] = 1'b1;
  end

  assign releaseReq = grant & {RS_ENTRIES{execute}};
  assign issueGo    = execute && (|grant);
  assign full       = &busy;

  assert property (@(posedge clk) disable iff (reset) dispatchValid |-> !full)
    else $error("dispatch while station full");

  assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
    else $error("grant is not one-hot");

endmodule

`default_nettype wire

// ==== logic/branchIssueStage.sv ====
/*
  Branch issue register stage
  Selects the granted entry and holds it for the resolve stage
*/
`timescale 1ns/1ns
`default_nettype none

module branchIssueStage (
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic                                                   flush,
  input  logic                                                   issueGo,
  input  logic                                                   execute,
  input  logic [branchPkg::RS_ENTRIES-1:0]                       grant,
  input  branchPkg::brCond_t [branchPkg::RS_ENTRIES-1:0]         entryCond,
  input  logic [branchPkg::RS_ENTRIES-1:0][branchPkg::ROB_BITS-1:0] entryRob,
  input  logic [branchPkg::RS_ENTRIES-1:0][branchPkg::XLEN-1:0]  entrySrc1,
  input  logic [branchPkg::RS_ENTRIES-1:0][branchPkg::XLEN-1:0]  entrySrc2,
  input  logic [branchPkg::RS_ENTRIES-1:0][branchPkg::XLEN-1:0]  entrySeqPc,
  input  logic [branchPkg::RS_ENTRIES-1:0][branchPkg::XLEN-1:0]  entryPredPc,
  input  logic [branchPkg::RS_ENTRIES-1:0][branchPkg::XLEN-1:0]  entryTarget,
  output logic                                                   issueValid,
  output branchPkg::brCond_t                                     issueCond,
  output logic [branchPkg::ROB_BITS-1:0]                         issueRob,
  output logic [branchPkg::XLEN-1:0]                             src1,
  output logic [branchPkg::XLEN-1:0]                             src2,
  output logic [branchPkg::XLEN-1:0]                             seqPc,
  output logic [branchPkg::XLEN-1:0]                             predPc,
  output logic [branchPkg::XLEN-1:0]                             target
);
  import branchPkg::*;

  logic [$clog2(RS_ENTRIES)-1:0] selIdx;

  // One-hot grant to entry index
  always_comb begin
    selIdx = '0;
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (grant[i]) selIdx = i[$clog2(RS_ENTRIES)-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) issueValid <= 1'b0;
    else if (execute) issueValid <= issueGo;
  end

  always_ff @(posedge clk) begin
    if (issueGo) begin
      issueCond <= entryCond[selIdx];
      issueRob  <= entryRob[selIdx];
      src1      <= entrySrc1[selIdx];
      src2      <= entrySrc2[selIdx];
      seqPc     <= entrySeqPc[selIdx];
      predPc    <= entryPredPc[selIdx];
      target    <= entryTarget[selIdx];
    end
  end

endmodule

`default_nettype wire

// ==== logic/branchResolve.sv ====
/*
  Branch resolve stage
  Evaluates the condition and registers next PC, link value and mispredict
*/
`timescale 1ns/1ns
`default_nettype none

module branchResolve (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush,
  input  logic                          execute,
  input  logic                          issueValid,
  input  branchPkg::brCond_t            issueCond,
  input  logic [branchPkg::ROB_BITS-1:0] issueRob,
  input  logic [branchPkg::XLEN-1:0]     src1,
  input  logic [branchPkg::XLEN-1:0]     src2,
  input  logic [branchPkg::XLEN-1:0]     seqPc,
  input  logic [branchPkg::XLEN-1:0]     predPc,
  input  logic [branchPkg::XLEN-1:0]     target,
  output logic                          resolveValid,
  output logic                          taken,
  output logic                          mispredict,
  output logic [branchPkg::ROB_BITS-1:0] resolveRob,
  output logic [branchPkg::XLEN-1:0]     nextPc,
  output logic [branchPkg::XLEN-1:0]     linkValue
);
  import branchPkg::*;

  logic            condTaken;
  logic            resolveNow;
  logic [XLEN-1:0] jumpTarget;
  logic [XLEN-1:0] actualPc;

  always_comb begin
    case (issueCond)
      BR_EQ:   condTaken = (src1 == src2);
      BR_NE:   condTaken = (src1 != src2);
      BR_LT:   condTaken = ($signed(src1) < $signed(src2));
      BR_GE:   condTaken = ($signed(src1) >= $signed(src2));
      BR_LTU:  condTaken = (src1 < src2);
      BR_GEU:  condTaken = (src1 >= src2);
      default: condTaken = 1'b1;
    endcase
  end

  // Register-relative jump drops bit zero of the sum
  assign jumpTarget = (issueCond == BR_JALR) ? ((src1 + target) & ~XLEN'(1)) : target;
  assign actualPc   = condTaken ? jumpTarget : seqPc;
  assign resolveNow = issueValid && execute;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      resolveValid <= 1'b0;
      mispredict   <= 1'b0;
    end else begin
      resolveValid <= resolveNow;
      mispredict   <= resolveNow && (actualPc != predPc);
    end
  end

  always_ff @(posedge clk) begin
    resolveRob <= issueRob;
    taken      <= condTaken;
    nextPc     <= actualPc;
    linkValue  <= seqPc;
  end

  assert property (@(posedge clk) disable iff (reset) mispredict |-> resolveValid)
    else $error("mispredict without a resolved branch");

endmodule

`default_nettype wire

// ==== logic/branchUnit.sv ====
/*
  Branch issue unit top level
  Two-entry station, oldest-first select, issue register and resolve stage
*/
`timescale 1ns/1ns
`default_nettype none

module branchUnit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush,
  input  logic                          execute,
  input  logic                          dispatchValid,
  input  branchPkg::brCond_t            cond,
  input  logic [branchPkg::ROB_BITS-1:0] rob,
  input  logic [branchPkg::XLEN-1:0]     seqPc,
  input  logic [branchPkg::XLEN-1:0]     predPc,
  input  logic [branchPkg::XLEN-1:0]     target,
  input  logic [branchPkg::XLEN-1:0]     value1,
  input  logic                          ready1,
  input  logic [branchPkg::ROB_BITS-1:0] tag1,
  input  logic [branchPkg::XLEN-1:0]     value2,
  input  logic                          ready2,
  input  logic [branchPkg::ROB_BITS-1:0] tag2,
  input  logic                          cdbValid,
  input  logic [branchPkg::ROB_BITS-1:0] cdbRob,
  input  logic [branchPkg::XLEN-1:0]     cdbValue,
  output logic                          full,
  output logic                          resolveValid,
  output logic [branchPkg::ROB_BITS-1:0] resolveRob,
  output logic [branchPkg::XLEN-1:0]     nextPc,
  output logic [branchPkg::XLEN-1:0]     linkValue,
  output logic                          taken,
  output logic                          mispredict
);
  import branchPkg::*;

  logic [RS_ENTRIES-1:0]               busy;
  logic [RS_ENTRIES-1:0]               selectReq;
  logic [RS_ENTRIES-1:0]               writeSel;
  logic [RS_ENTRIES-1:0]               grant;
  logic [RS_ENTRIES-1:0]               releaseReq;
  logic                                issueGo;
  brCond_t [RS_ENTRIES-1:0]            entryCond;
  logic [RS_ENTRIES-1:0][ROB_BITS-1:0] entryRob;
  logic [RS_ENTRIES-1:0][XLEN-1:0]     entrySrc1;
  logic [RS_ENTRIES-1:0][XLEN-1:0]     entrySrc2;
  logic [RS_ENTRIES-1:0][XLEN-1:0]     entrySeqPc;
  logic [RS_ENTRIES-1:0][XLEN-1:0]     entryPredPc;
  logic [RS_ENTRIES-1:0][XLEN-1:0]     entryTarget;

  logic                issueValid;
  brCond_t             issueCond;
  logic [ROB_BITS-1:0] issueRob;
  logic [XLEN-1:0]     issueSrc1;
  logic [XLEN-1:0]     issueSrc2;
  logic [XLEN-1:0]     issueSeqPc;
  logic [XLEN-1:0]     issuePredPc;
  logic [XLEN-1:0]     issueTarget;

  // ============================================================
  // Station entries
  // ============================================================
  for (genvar i = 0; i < RS_ENTRIES; i++) begin : genEntry
    branchRsEntry i_entry (
      .clk, .reset, .flush,
      .write(writeSel[i]),
      .cond, .rob, .tag1, .tag2, .seqPc, .predPc, .target,
      .value1, .value2, .ready1, .ready2,
      .cdbValid, .cdbRob, .cdbValue,
      .releaseReq(releaseReq[i]),
      .busy(busy[i]),
      .selectReq(selectReq[i]),
      .entryCond(entryCond[i]),
      .entryRob(entryRob[i]),
      .entrySrc1(entrySrc1[i]),
      .entrySrc2(entrySrc2[i]),
      .entrySeqPc(entrySeqPc[i]),
      .entryPredPc(entryPredPc[i]),
      .entryTarget(entryTarget[i])
    );
  end

  branchSelect i_select (
    .clk, .reset, .flush, .dispatchValid, .execute,
    .busy, .selectReq, .writeSel, .grant, .releaseReq, .issueGo, .full
  );

  // ============================================================
  // Issue and resolve pipeline
  // ============================================================
  branchIssueStage i_issue (
    .clk, .reset, .flush, .issueGo, .execute, .grant,
    .entryCond, .entryRob, .entrySrc1, .entrySrc2,
    .entrySeqPc, .entryPredPc, .entryTarget,
    .issueValid, .issueCond, .issueRob,
    .src1(issueSrc1), .src2(issueSrc2), .seqPc(issueSeqPc),
    .predPc(issuePredPc), .target(issueTarget)
  );

  branchResolve i_resolve (
    .clk, .reset, .flush, .execute, .issueValid, .issueCond, .issueRob,
    .src1(issueSrc1), .src2(issueSrc2), .seqPc(issueSeqPc),
    .predPc(issuePredPc), .target(issueTarget),
    .resolveValid, .taken, .mispredict, .resolveRob, .nextPc, .linkValue
  );

endmodule

`default_nettype wire

// ==== dv/tbChecker.sv ====
/*
  Branch unit checker
  Scoreboards dispatched branches and compares every resolve with a reference
*/
`timescale 1ns/1ns
`default_nettype none

module tbChecker (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           flush,
  input  logic                           execute,
  input  logic                           dispatchValid,
  input  branchPkg::brCond_t             cond,
  input  logic [branchPkg::ROB_BITS-1:0] rob,
  input  logic [branchPkg::XLEN-1:0]     seqPc,
  input  logic [branchPkg::XLEN-1:0]     predPc,
  input  logic [branchPkg::XLEN-1:0]     target,
  input  logic [branchPkg::XLEN-1:0]     value1,
  input  logic                           ready1,
  input  logic [branchPkg::ROB_BITS-1:0] tag1,
  input  logic [branchPkg::XLEN-1:0]     value2,
  input  logic                           ready2,
  input  logic [branchPkg::ROB_BITS-1:0] tag2,
  input  logic                           cdbValid,
  input  logic [branchPkg::ROB_BITS-1:0] cdbRob,
  input  logic [branchPkg::XLEN-1:0]     cdbValue,
  input  logic                           full,
  input  logic                           resolveValid,
  input  logic [branchPkg::ROB_BITS-1:0] resolveRob,
  input  logic [branchPkg::XLEN-1:0]     nextPc,
  input  logic [branchPkg::XLEN-1:0]     linkValue,
  input  logic                           taken,
  input  logic                           mispredict,
  output logic                           idle,
  output int                             errorCount
);
  import branchPkg::*;

  localparam int TAGS = 1 << ROB_BITS;

  logic                pend    [TAGS];
  logic                fast    [TAGS];
  int                  fastDue [TAGS];
  brCond_t             pCond   [TAGS];
  logic                pR1     [TAGS];
  logic                pR2     [TAGS];
  logic [ROB_BITS-1:0] pT1     [TAGS];
  logic [ROB_BITS-1:0] pT2     [TAGS];
  logic [XLEN-1:0]     pS1     [TAGS];
  logic [XLEN-1:0]     pS2     [TAGS];
  logic [XLEN-1:0]     pSeq    [TAGS];
  logic [XLEN-1:0]     pPred   [TAGS];
  logic [XLEN-1:0]     pTgt    [TAGS];
  logic [ROB_BITS-1:0] orderQ  [$];
  int                  edgeNum;
  int                  pendCount;
  int                  stuck;

  initial begin
    errorCount = 0;
    edgeNum    = 0;
    pendCount  = 0;
    stuck      = 0;
  end

  assign idle = (pendCount == 0);

  // Expected {taken, nextPc} from the branch rules
  function automatic logic [XLEN:0] refResolve(input brCond_t c, input logic [XLEN-1:0] a,
      input logic [XLEN-1:0] b, input logic [XLEN-1:0] seq, input logic [XLEN-1:0] tgt);
    logic            tk;
    logic [XLEN-1:0] dest;
    dest = tgt;
    case (c)
      BR_EQ:   tk = (a == b);
      BR_NE:   tk = (a != b);
      BR_LT:   tk = ($signed(a) < $signed(b));
      BR_GE:   tk = !($signed(a) < $signed(b));
      BR_LTU:  tk = (a < b);
      BR_GEU:  tk = !(a < b);
      BR_JALR: begin
        tk      = 1'b1;
        dest    = a + tgt;
        dest[0] = 1'b0;
      end
      default: tk = 1'b1;
    endcase
    return {tk, tk ? dest : seq};
  endfunction

  task automatic reportError(input string what);
    $display("Error at %0t: %s", $time, what);
    errorCount++;
  endtask

  task automatic compareField(input string name, input logic [XLEN-1:0] expected,
      input logic [XLEN-1:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h got %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic clearAll();
    foreach (pend[i]) begin
      pend[i] = 1'b0;
      fast[i] = 1'b0;
    end
    pendCount = 0;
    stuck     = 0;
    orderQ.delete();
  endtask

  // ============================================================
  // Resolve comparison
  // ============================================================
  task automatic checkResolve();
    logic [ROB_BITS-1:0] r;
    logic [XLEN:0]       expResult;
    int                  pos;
    r = resolveRob;
    if (!pend[r]) begin
      reportError($sformatf("rob %0d resolved but no branch with that tag is pending", r));
    end else if (!(pR1[r] && pR2[r])) begin
      reportError($sformatf("rob %0d resolved before its operands were broadcast", r));
    end else begin
      expResult = refResolve(pCond[r], pS1[r], pS2[r], pSeq[r], pTgt[r]);
      compareField("taken", XLEN'(expResult[XLEN]), XLEN'(taken));
      compareField("nextPc", expResult[XLEN-1:0], nextPc);
      compareField("linkValue", pSeq[r], linkValue);
      compareField("mispredict", XLEN'(expResult[XLEN-1:0] != pPred[r]), XLEN'(mispredict));
      if (fast[r] && edgeNum != fastDue[r]) begin
        reportError($sformatf("rob %0d resolved %0d edges after its write edge, expected 2",
                              r, edgeNum - fastDue[r] + 2));
      end
      // Ready-at-dispatch branches leave in dispatch order
      pos = -1;
      foreach (orderQ[i]) begin
        if (orderQ[i] == r) pos = i;
      end
      if (pos > 0) reportError($sformatf("rob %0d resolved ahead of an older ready branch", r));
      if (pos >= 0) orderQ.delete(pos);
    end
    if (pend[r]) begin
      pend[r] = 1'b0;
      pendCount--;
    end
  endtask

  task automatic wakeOperands();
    for (int i = 0; i < TAGS; i++) begin
      if (pend[i] && !pR1[i] && pT1[i] == cdbRob) begin
        pS1[i] = cdbValue;
        pR1[i] = 1'b1;
      end
      if (pend[i] && !pR2[i] && pT2[i] == cdbRob) begin
        pS2[i] = cdbValue;
        pR2[i] = 1'b1;
      end
    end
  endtask

  task automatic recordDispatch();
    if (pend[rob]) begin
      reportError($sformatf("rob %0d dispatched while still pending", rob));
    end else begin
      pCond[rob] = cond;
      pSeq[rob]  = seqPc;
      pPred[rob] = predPc;
      pTgt[rob]  = target;
      pT1[rob]   = tag1;
      pT2[rob]   = tag2;
      pR1[rob]   = ready1 || (cdbValid && cdbRob == tag1);
      pR2[rob]   = ready2 || (cdbValid && cdbRob == tag2);
      pS1[rob]   = ready1 ? value1 : cdbValue;
      pS2[rob]   = ready2 ? value2 : cdbValue;
      // Empty station and ready operands give the fixed latency
      fast[rob]    = (pendCount == 0) && pR1[rob] && pR2[rob];
      fastDue[rob] = edgeNum + 3;
      if (pR1[rob] && pR2[rob]) orderQ.push_back(rob);
      pend[rob] = 1'b1;
      pendCount++;
    end
    stuck++;
  endtask

  // ============================================================
  // Per-edge scoreboard update
  // ============================================================
  always @(posedge clk) begin
    edgeNum++;
    if (reset) begin
      clearAll();
    end else begin
      if (full && pendCount < 2) reportError("full is high with fewer than two branches held");
      if (stuck >= 2) compareField("full", XLEN'(1), XLEN'(full));
      if (resolveValid) checkResolve();
      if (flush) begin
        clearAll();
      end else begin
        if (execute) begin
          stuck = 0;
        end else begin
          foreach (fast[i]) fast[i] = 1'b0;
        end
        if (cdbValid) wakeOperands();
        if (dispatchValid) recordDispatch();
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tbBranchUnit.sv ====
/*
  Branch unit testbench
  Directed and random dispatch, wakeup, back-pressure and flush tests
*/
`timescale 1ns/1ns
`default_nettype none

module tbBranchUnit;
  import branchPkg::*;

  localparam int BRANCHES    = 32;
  localparam int CYCLE_LIMIT = 40 * BRANCHES + 100;

  logic                clk;
  logic                reset;
  logic                flush;
  logic                execute;
  logic                dispatchValid;
  brCond_t             cond;
  logic [ROB_BITS-1:0] rob;
  logic [XLEN-1:0]     seqPc;
  logic [XLEN-1:0]     predPc;
  logic [XLEN-1:0]     target;
  logic [XLEN-1:0]     value1;
  logic                ready1;
  logic [ROB_BITS-1:0] tag1;
  logic [XLEN-1:0]     value2;
  logic                ready2;
  logic [ROB_BITS-1:0] tag2;
  logic                cdbValid;
  logic [ROB_BITS-1:0] cdbRob;
  logic [XLEN-1:0]     cdbValue;
  logic                full;
  logic                resolveValid;
  logic [ROB_BITS-1:0] resolveRob;
  logic [XLEN-1:0]     nextPc;
  logic [XLEN-1:0]     linkValue;
  logic                taken;
  logic                mispredict;
  logic                idle;
  int                  errorCount;
  int                  cycleCount;
  int                  sent;
  logic [31:0]         lfsr;
  logic [ROB_BITS-1:0] nextRob;

  branchUnit i_dut (.*);

  tbChecker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d errors, a branch never resolved",
               cycleCount, errorCount);
      $display("Test failures found");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  task automatic stepCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic dispatch(input brCond_t c, input logic r1, input logic [ROB_BITS-1:0] t1,
      input logic r2, input logic [ROB_BITS-1:0] t2);
    while (full) stepCycle();
    cond   = c;
    rob    = nextRob;
    ready1 = r1;
    tag1   = t1;
    ready2 = r2;
    tag2   = t2;
    seqPc  = randBits(30) << 2;
    target = randBits(30) << 2;
    value1 = randBits(32);
    // Equal operands half the time so EQ and NE go both ways
    value2 = randBits(1) ? value1 : randBits(32);
    predPc = randBits(1) ? target : seqPc;
    dispatchValid = 1'b1;
    stepCycle();
    dispatchValid = 1'b0;
    nextRob++;
    sent++;
  endtask

  task automatic broadcast(input logic [ROB_BITS-1:0] tag, input logic [XLEN-1:0] value);
    cdbValid = 1'b1;
    cdbRob   = tag;
    cdbValue = value;
    stepCycle();
    cdbValid = 1'b0;
  endtask

  task automatic waitIdle();
    while (!idle) stepCycle();
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    int n;
    lfsr = 32'd47;
    cycleCount = 0;
    sent = 0;
    nextRob = '0;
    reset = 1'b1;
    flush = 1'b0;
    execute = 1'b1;
    dispatchValid = 1'b0;
    cond = BR_EQ;
    rob = '0;
    seqPc = '0;
    predPc = '0;
    target = '0;
    value1 = '0;
    ready1 = 1'b0;
    tag1 = '0;
    value2 = '0;
    ready2 = 1'b0;
    tag2 = '0;
    cdbValid = 1'b0;
    cdbRob = '0;
    cdbValue = '0;
    repeat (8) stepCycle();
    reset = 1'b0;

    // Ready branch into an empty station
    dispatch(BR_JAL, 1'b1, '0, 1'b1, '0);
    waitIdle();

    // Every branch kind back to back
    for (int i = 0; i < 16; i++) begin
      dispatch(brCond_t'(i % 8), 1'b1, '0, 1'b1, '0);
    end
    waitIdle();

    // Operand wakeup after dispatch and in the dispatch cycle
    dispatch(BR_EQ, 1'b0, 3'd5, 1'b1, '0);
    repeat (3) stepCycle();
    broadcast(3'd4, randBits(32));
    repeat (3) stepCycle();
    // EQ is taken only when the tag 5 value reaches src1
    broadcast(3'd5, value2);
    waitIdle();
    cdbValid = 1'b1;
    cdbRob   = 3'd6;
    cdbValue = randBits(32);
    dispatch(BR_LTU, 1'b1, '0, 1'b0, 3'd6);
    cdbValid = 1'b0;
    waitIdle();

    // Oldest first and then with the older branch in entry one
    execute = 1'b0;
    dispatch(BR_NE, 1'b1, '0, 1'b1, '0);
    dispatch(BR_GE, 1'b1, '0, 1'b1, '0);
    execute = 1'b1;
    stepCycle();
    execute = 1'b0;
    dispatch(BR_LT, 1'b1, '0, 1'b1, '0);
    execute = 1'b1;
    waitIdle();

    // Random back-pressure
    n = 0;
    while (n < 8) begin
      execute = randBits(1);
      if (!full && randBits(1)) begin
        dispatch(brCond_t'(randBits(3)), 1'b1, '0, 1'b1, '0);
        n++;
      end else begin
        stepCycle();
      end
    end
    execute = 1'b1;
    waitIdle();

    // Flush drops the held branches
    execute = 1'b0;
    dispatch(BR_GEU, 1'b1, '0, 1'b1, '0);
    dispatch(BR_JALR, 1'b1, '0, 1'b1, '0);
    flush = 1'b1;
    stepCycle();
    flush = 1'b0;
    execute = 1'b1;
    repeat (6) stepCycle();
    waitIdle();

    repeat (4) stepCycle();
    $display("Run finished with %0d errors over %0d branches", errorCount, sent);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/branchPkg.sv
logic/branchRsEntry.sv
logic/branchSelect.sv
logic/branchIssueStage.sv
logic/branchResolve.sv
logic/branchUnit.sv
dv/tbChecker.sv
dv/tbBranchUnit.sv
